// File: hdl/ex_cfg.svh
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

`define EX_XLEN  32 // data word.
`define EX_REG_W 5  // destination register index.
`define EX_CSR_W 14 // csr address.

`endif

// File: hdl/ex_isa_pkg.sv
package ex_isa_pkg;

    // bit 4 clear is an alu op, 2'b10 in [4:3] a multiply, 2'b11 a divide.
    typedef enum logic [4:0] {
        OP_ADD   = 5'h00,
        OP_SUB   = 5'h01,
        OP_SLT   = 5'h02,
        OP_SLTU  = 5'h03,
        OP_EQ    = 5'h04,
        OP_AND   = 5'h05,
        OP_OR    = 5'h06,
        OP_XOR   = 5'h07,
        OP_NOR   = 5'h08,
        OP_SLL   = 5'h09,
        OP_SRL   = 5'h0a,
        OP_SRA   = 5'h0b,
        OP_LUI   = 5'h0c,
        OP_MUL   = 5'h10,
        OP_MULH  = 5'h11,
        OP_MULHU = 5'h12,
        OP_DIV   = 5'h18,
        OP_MOD   = 5'h19,
        OP_DIVU  = 5'h1a,
        OP_MODU  = 5'h1b
    } opcode_t;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_type_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [3:0] {
        EXC_NONE = 4'd0,
        EXC_INT  = 4'd1,  // interrupt.
        EXC_ADEF = 4'd2,  // fetch address error.
        EXC_ADEM = 4'd3,
        EXC_ALE  = 4'd4,  // misaligned access.
        EXC_SYS  = 4'd5,
        EXC_BRK  = 4'd6,
        EXC_INE  = 4'd7,  // undefined instruction.
        EXC_IPE  = 4'd8
    } exception_t;

endpackage

// File: hdl/ex_pipe_pkg.sv
`include "ex_cfg.svh"

package ex_pipe_pkg;

    // one issue slot as handed over by register read.
    typedef struct packed {
        logic                   valid;
        logic [`EX_XLEN-1:0]    pc;
        logic                   have_exception;
        ex_isa_pkg::exception_t exception_type;
        ex_isa_pkg::opcode_t    opcode;
        logic [`EX_XLEN-1:0]    src1;
        logic [`EX_XLEN-1:0]    src2;
        logic [`EX_REG_W-1:0]   dest;
        logic                   is_branch;
        logic                   branch_condition;
        logic [`EX_XLEN-1:0]    branch_target;
        logic                   is_jirl;
        logic                   pred_branch_taken;
        logic [`EX_XLEN-1:0]    pred_branch_target;
        ex_isa_pkg::mem_type_t  mem_type;
        ex_isa_pkg::mem_size_t  mem_size;
        logic [`EX_XLEN-1:0]    st_data;
        logic                   is_csr_op;
        logic [`EX_CSR_W-1:0]   csr_addr;
        logic [`EX_XLEN-1:0]    csr_mask;
    } issue_slot_t;

    typedef struct packed {
        logic                   valid;
        logic                   forwardable;
        logic [`EX_XLEN-1:0]    pc;
        logic                   have_exception;
        ex_isa_pkg::exception_t exception_type;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_REG_W-1:0]   dest;
        logic                   branch_taken;
        logic [`EX_XLEN-1:0]    branch_target;
        logic                   branch_mistaken;
        ex_isa_pkg::mem_type_t  mem_type;
        ex_isa_pkg::mem_size_t  mem_size;
        logic [`EX_XLEN-1:0]    st_data;
        logic                   is_csr_op;
        logic [`EX_CSR_W-1:0]   csr_addr;
        logic [`EX_XLEN-1:0]    csr_mask;
    } ex_slot_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] hi;
        logic [`EX_XLEN-1:0] lo;
    } mul_res_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] quot;
        logic [`EX_XLEN-1:0] rem;
    } div_res_t;

    // same lane register, read as product or as quotient/remainder.
    typedef union packed {
        mul_res_t prod;
        div_res_t quo_rem;
    } long_res_u;

endpackage

// File: hdl/ex_alu.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_alu (
    input  ex_isa_pkg::opcode_t op,
    input  logic [`EX_XLEN-1:0] src1,
    input  logic [`EX_XLEN-1:0] src2,
    output logic [`EX_XLEN-1:0] result
);

    logic [4:0] shamt;

    assign shamt = src2[4:0];

    always_comb begin
        result = '0;
        case (op)
            ex_isa_pkg::OP_ADD:  result = src1 + src2;
            ex_isa_pkg::OP_SUB:  result = src1 - src2;
            // compares land in bit 0 for the branch condition.
            ex_isa_pkg::OP_SLT:  result[0] = $signed(src1) < $signed(src2);
            ex_isa_pkg::OP_SLTU: result[0] = src1 < src2;
            ex_isa_pkg::OP_EQ:   result[0] = src1 == src2;
            ex_isa_pkg::OP_AND:  result = src1 & src2;
            ex_isa_pkg::OP_OR:   result = src1 | src2;
            ex_isa_pkg::OP_XOR:  result = src1 ^ src2;
            ex_isa_pkg::OP_NOR:  result = ~(src1 | src2);
            ex_isa_pkg::OP_SLL:  result = src1 << shamt;
            ex_isa_pkg::OP_SRL:  result = src1 >> shamt;
            ex_isa_pkg::OP_SRA:  result = $signed(src1) >>> shamt;
            ex_isa_pkg::OP_LUI:  result = {src2[19:0], 12'h000}; // upper immediate.
            default:             result = '0;
        endcase
    end

endmodule

// File: hdl/ex_muldiv.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_muldiv (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   start,
    input  ex_isa_pkg::opcode_t    op,
    input  logic [`EX_XLEN-1:0]    src1,
    input  logic [`EX_XLEN-1:0]    src2,
    output logic                   done,
    output ex_pipe_pkg::long_res_u res
);

    logic                  busy;
    logic [5:0]            count;
    logic                  is_div;
    logic                  signed_div;
    logic                  mul_signed;
    logic [63:0]           prod;
    logic [`EX_XLEN-1:0]   mag1;
    logic [`EX_XLEN-1:0]   mag2;
    logic [`EX_XLEN-1:0]   divisor;
    logic [`EX_XLEN-1:0]   quo;
    logic [`EX_XLEN-1:0]   rem_acc;
    logic                  q_neg;
    logic                  r_neg;
    logic [`EX_XLEN:0]     rem_shift;
    logic [`EX_XLEN+1:0]   diff;
    logic [`EX_XLEN-1:0]   quo_next;
    logic [`EX_XLEN-1:0]   rem_next;

    assign is_div     = op[4:3] == 2'b11;
    assign signed_div = op == ex_isa_pkg::OP_DIV || op == ex_isa_pkg::OP_MOD;
    assign mul_signed = op == ex_isa_pkg::OP_MULH;

    // 33-bit operands cover both signed and unsigned products.
    assign prod = $signed({mul_signed & src1[31], src1}) * $signed({mul_signed & src2[31], src2});

    assign mag1 = (signed_div && src1[31]) ? -src1 : src1;
    assign mag2 = (signed_div && src2[31]) ? -src2 : src2;

    // one restoring shift-subtract step.
    assign rem_shift = {rem_acc, quo[31]};
    assign diff      = {1'b0, rem_shift} - {2'b00, divisor};
    assign quo_next  = {quo[30:0], ~diff[`EX_XLEN+1]};
    assign rem_next  = diff[`EX_XLEN+1] ? rem_shift[`EX_XLEN-1:0] : diff[`EX_XLEN-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0; // abort.
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy  <= is_div;
                count <= 6'd32;
                done  <= !is_div; // multiply finishes in one cycle.
            end else if (busy) begin
                count <= count - 6'd1;
                if (count == 6'd1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !is_div) begin
            res.prod <= prod;
        end else if (start) begin
            divisor <= mag2;
            quo     <= mag1;
            rem_acc <= '0;
            q_neg   <= signed_div & (src1[31] ^ src2[31]);
            r_neg   <= signed_div & src1[31];
        end else if (busy) begin
            quo     <= quo_next;
            rem_acc <= rem_next;
            if (count == 6'd1) begin
                res.quo_rem.quot <= q_neg ? -quo_next : quo_next;
                res.quo_rem.rem  <= r_neg ? -rem_next : rem_next;
            end
        end
    end

    // ----------------------------------------
    a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        start |-> !busy);
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done);

endmodule

// File: hdl/ex_branch.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_branch (
    input  ex_pipe_pkg::issue_slot_t slot,
    input  logic [`EX_XLEN-1:0]      alu_value,
    input  logic                     stall,
    output logic                     taken,
    output logic [`EX_XLEN-1:0]      target,
    output logic                     mistaken
);

    logic dir_wrong;
    logic tgt_wrong;

    // conditional branches compare the alu flag in bit 0.
    assign taken  = slot.is_branch & (slot.is_jirl | (slot.branch_condition == alu_value[0]));
    assign target = slot.is_jirl ? alu_value : slot.branch_target;

    assign dir_wrong = taken != slot.pred_branch_taken;
    assign tgt_wrong = taken & (target != slot.pred_branch_target);

    // only reported once, on the cycle the bundle leaves.
    assign mistaken = slot.valid & ~stall & (dir_wrong | tgt_wrong);

endmodule

// File: hdl/ex_ctrl.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_ctrl (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     allowout,
    input  logic                     ro_ready,
    input  ex_pipe_pkg::issue_slot_t ro_a,
    input  ex_pipe_pkg::issue_slot_t ro_b,
    input  logic [`EX_XLEN-1:0]      alu_a,
    input  logic [`EX_XLEN-1:0]      alu_b,
    input  ex_pipe_pkg::long_res_u   long_a,
    input  ex_pipe_pkg::long_res_u   long_b,
    input  logic                     done_a,
    input  logic                     done_b,
    input  logic                     taken_a,
    input  logic                     taken_b,
    input  logic [`EX_XLEN-1:0]      target_a,
    input  logic [`EX_XLEN-1:0]      target_b,
    input  logic                     mistaken_a,
    input  logic                     mistaken_b,
    output ex_pipe_pkg::issue_slot_t cur_a,
    output ex_pipe_pkg::issue_slot_t cur_b,
    output logic                     start_a,
    output logic                     start_b,
    output logic                     ex_valid,
    output logic                     ex_ready,
    output logic                     ex_stall,
    output ex_pipe_pkg::ex_slot_t    ex_a,
    output ex_pipe_pkg::ex_slot_t    ex_b
);

    logic pend_a;
    logic pend_b;
    logic busy_a;
    logic busy_b;
    logic load;

    function automatic logic [`EX_XLEN-1:0] pick_result(
        input ex_pipe_pkg::issue_slot_t s,
        input logic [`EX_XLEN-1:0]      alu,
        input ex_pipe_pkg::long_res_u   lr
    );
        if (s.is_jirl)
            return s.pc + 32'd4; // link address.
        if (!s.opcode[4])
            return alu;
        case (s.opcode)
            ex_isa_pkg::OP_MUL:   return lr.prod.lo;
            ex_isa_pkg::OP_MULH,
            ex_isa_pkg::OP_MULHU: return lr.prod.hi;
            ex_isa_pkg::OP_DIV,
            ex_isa_pkg::OP_DIVU:  return lr.quo_rem.quot;
            default:              return lr.quo_rem.rem;
        endcase
    endfunction

    function automatic ex_pipe_pkg::ex_slot_t build_slot(
        input ex_pipe_pkg::issue_slot_t s,
        input logic                     ready,
        input logic [`EX_XLEN-1:0]      result,
        input logic                     taken,
        input logic [`EX_XLEN-1:0]      target,
        input logic                     mistaken
    );
        ex_pipe_pkg::ex_slot_t o;
        o.valid           = s.valid;
        o.forwardable     = ready & ~s.have_exception & ~s.is_csr_op
                          & (s.mem_type == ex_isa_pkg::MEM_NOP);
        o.pc              = s.pc;
        o.have_exception  = s.have_exception;
        o.exception_type  = s.exception_type;
        o.result          = result;
        o.dest            = s.dest;
        o.branch_taken    = taken;
        o.branch_target   = target;
        o.branch_mistaken = mistaken;
        o.mem_type        = s.mem_type;
        o.mem_size        = s.mem_size;
        o.st_data         = s.st_data;
        o.is_csr_op       = s.valid & s.is_csr_op;
        o.csr_addr        = s.csr_addr;
        o.csr_mask        = s.csr_mask;
        return o;
    endfunction

    // a lane waits from its start pulse until done.
    assign busy_a = start_a | (pend_a & ~done_a);
    assign busy_b = start_b | (pend_b & ~done_b);

    assign ex_valid = cur_a.valid | cur_b.valid;
    assign ex_ready = ex_valid & ~busy_a & ~busy_b;
    assign ex_stall = ex_valid & (~ex_ready | ~allowout);
    assign load     = ~flush & ~ex_stall & ro_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cur_a <= '0;
            cur_b <= '0;
        end else if (flush || (!ex_stall && !ro_ready)) begin
            cur_a.valid <= 1'b0;
            cur_b.valid <= 1'b0;
        end else if (!ex_stall) begin
            cur_a <= ro_a;
            cur_b <= ro_b;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            start_a <= 1'b0;
            start_b <= 1'b0;
            pend_a  <= 1'b0;
            pend_b  <= 1'b0;
        end else begin
            start_a <= load & ro_a.valid & ro_a.opcode[4];
            start_b <= load & ro_b.valid & ro_b.opcode[4];
            pend_a  <= ~flush & (start_a | (pend_a & ~done_a));
            pend_b  <= ~flush & (start_b | (pend_b & ~done_b));
        end
    end

    assign ex_a = build_slot(cur_a, cur_a.valid & ~busy_a, pick_result(cur_a, alu_a, long_a),
                             taken_a, target_a, mistaken_a);
    assign ex_b = build_slot(cur_b, cur_b.valid & ~busy_b, pick_result(cur_b, alu_b, long_b),
                             taken_b, target_b, mistaken_b);

    // ----------------------------------------
    // a pending long op always belongs to a live slot.
    a_busy_valid_a: assert property (@(posedge clk) disable iff (!arst_n)
        busy_a |-> cur_a.valid);
    a_busy_valid_b: assert property (@(posedge clk) disable iff (!arst_n)
        busy_b |-> cur_b.valid);
    a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ex_stall && !flush |=> $stable(cur_a) && $stable(cur_b));

endmodule

// File: hdl/ex_stage.sv
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     flush,
    input  logic                     allowout,
    input  logic                     ro_ready,
    input  ex_pipe_pkg::issue_slot_t ro_a,
    input  ex_pipe_pkg::issue_slot_t ro_b,
    output logic                     ex_valid,
    output logic                     ex_ready,
    output logic                     ex_stall,
    output ex_pipe_pkg::ex_slot_t    ex_a,
    output ex_pipe_pkg::ex_slot_t    ex_b
);

    ex_pipe_pkg::issue_slot_t cur_a;
    ex_pipe_pkg::issue_slot_t cur_b;
    ex_pipe_pkg::long_res_u   long_a;
    ex_pipe_pkg::long_res_u   long_b;
    logic [`EX_XLEN-1:0]      alu_a;
    logic [`EX_XLEN-1:0]      alu_b;
    logic [`EX_XLEN-1:0]      target_a;
    logic [`EX_XLEN-1:0]      target_b;
    logic                     start_a;
    logic                     start_b;
    logic                     done_a;
    logic                     done_b;
    logic                     taken_a;
    logic                     taken_b;
    logic                     mistaken_a;
    logic                     mistaken_b;

    ex_ctrl u_ctrl (
        .clk, .arst_n, .flush, .allowout, .ro_ready, .ro_a, .ro_b,
        .alu_a, .alu_b, .long_a, .long_b, .done_a, .done_b,
        .taken_a, .taken_b, .target_a, .target_b, .mistaken_a, .mistaken_b,
        .cur_a, .cur_b, .start_a, .start_b,
        .ex_valid, .ex_ready, .ex_stall, .ex_a, .ex_b
    );

    // ---------------- lane a ----------------
    ex_alu u_alu_a (.op(cur_a.opcode), .src1(cur_a.src1), .src2(cur_a.src2), .result(alu_a));

    ex_muldiv u_muldiv_a (
        .clk, .arst_n, .flush, .start(start_a), .op(cur_a.opcode),
        .src1(cur_a.src1), .src2(cur_a.src2), .done(done_a), .res(long_a)
    );

    ex_branch u_branch_a (
        .slot(cur_a), .alu_value(alu_a), .stall(ex_stall),
        .taken(taken_a), .target(target_a), .mistaken(mistaken_a)
    );

    // ---------------- lane b ----------------
    ex_alu u_alu_b (.op(cur_b.opcode), .src1(cur_b.src1), .src2(cur_b.src2), .result(alu_b));

    ex_muldiv u_muldiv_b (
        .clk, .arst_n, .flush, .start(start_b), .op(cur_b.opcode),
        .src1(cur_b.src1), .src2(cur_b.src2), .done(done_b), .res(long_b)
    );

    ex_branch u_branch_b (
        .slot(cur_b), .alu_value(alu_b), .stall(ex_stall),
        .taken(taken_b), .target(target_b), .mistaken(mistaken_b)
    );

endmodule

// File: testbench/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb;

    logic clk = 1'b0;
    logic arst_n;
    logic flush;
    logic allowout;
    logic ro_ready;
    logic ex_valid;
    logic ex_ready;
    logic ex_stall;
    logic bp_on;
    ex_pipe_pkg::issue_slot_t ro_a;
    ex_pipe_pkg::issue_slot_t ro_b;
    ex_pipe_pkg::ex_slot_t    ex_a;
    ex_pipe_pkg::ex_slot_t    ex_b;
    ex_pipe_pkg::ex_slot_t    exp_a_q[$];
    ex_pipe_pkg::ex_slot_t    exp_b_q[$];
    integer seed = 32'ha548;
    int     errors;
    int     checks;
    int     sent;
    int     done_cnt;

    ex_stage i_ex_stage (.*);

    always #20 clk = ~clk;

    // ----------------------------------------
    function automatic ex_pipe_pkg::ex_slot_t ex_ref(input ex_pipe_pkg::issue_slot_t s);
        logic [31:0] a, b, alu, m1, m2, q, r;
        logic [63:0] p;
        logic        sd;
        ex_pipe_pkg::ex_slot_t o;
        a = s.src1;
        b = s.src2;
        case (s.opcode)
            ex_isa_pkg::OP_ADD:  alu = a + b;
            ex_isa_pkg::OP_SUB:  alu = a - b;
            ex_isa_pkg::OP_SLT:  alu = {31'b0, $signed(a) < $signed(b)};
            ex_isa_pkg::OP_SLTU: alu = {31'b0, a < b};
            ex_isa_pkg::OP_EQ:   alu = {31'b0, a == b};
            ex_isa_pkg::OP_AND:  alu = a & b;
            ex_isa_pkg::OP_OR:   alu = a | b;
            ex_isa_pkg::OP_XOR:  alu = a ^ b;
            ex_isa_pkg::OP_NOR:  alu = ~(a | b);
            ex_isa_pkg::OP_SLL:  alu = a << b[4:0];
            ex_isa_pkg::OP_SRL:  alu = a >> b[4:0];
            ex_isa_pkg::OP_SRA:  alu = $signed(a) >>> b[4:0];
            ex_isa_pkg::OP_LUI:  alu = {b[19:0], 12'h000};
            default:             alu = '0;
        endcase
        if (s.opcode == ex_isa_pkg::OP_MULH)
            p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        else
            p = {32'b0, a} * {32'b0, b};
        sd = s.opcode == ex_isa_pkg::OP_DIV || s.opcode == ex_isa_pkg::OP_MOD;
        m1 = (sd && a[31]) ? -a : a;
        m2 = (sd && b[31]) ? -b : b;
        q  = (m2 == 0) ? '1 : m1 / m2;
        r  = (m2 == 0) ? m1 : m1 % m2;
        if (sd && (a[31] ^ b[31])) q = -q;
        if (sd && a[31]) r = -r;
        o = '0;
        o.valid          = s.valid;
        o.forwardable    = s.valid & !s.have_exception & !s.is_csr_op
                         & (s.mem_type == ex_isa_pkg::MEM_NOP);
        o.pc             = s.pc;
        o.have_exception = s.have_exception;
        o.exception_type = s.exception_type;
        o.dest           = s.dest;
        if (s.is_jirl)            o.result = s.pc + 32'd4;
        else if (!s.opcode[4])    o.result = alu;
        else if (s.opcode == ex_isa_pkg::OP_MUL) o.result = p[31:0];
        else if (!s.opcode[3])    o.result = p[63:32];
        else if (!s.opcode[0])    o.result = q; // div and divu.
        else                      o.result = r;
        o.branch_taken    = s.is_branch & (s.is_jirl | (s.branch_condition == alu[0]));
        o.branch_target   = s.is_jirl ? alu : s.branch_target;
        o.branch_mistaken = s.valid & ((o.branch_taken != s.pred_branch_taken)
                          | (o.branch_taken & (o.branch_target != s.pred_branch_target)));
        o.mem_type  = s.mem_type;
        o.mem_size  = s.mem_size;
        o.st_data   = s.st_data;
        o.is_csr_op = s.valid & s.is_csr_op;
        o.csr_addr  = s.csr_addr;
        o.csr_mask  = s.csr_mask;
        return o;
    endfunction

    // ops 0..12 alu, 13..15 multiply, 16..19 divide.
    function automatic ex_isa_pkg::opcode_t pick_op(input int lo, input int n);
        logic [31:0] r;
        int          k;
        r = $random(seed);
        k = lo + int'(r % n);
        if (k < 13) return ex_isa_pkg::opcode_t'(5'(k));
        if (k < 16) return ex_isa_pkg::opcode_t'(5'(k + 3));
        return ex_isa_pkg::opcode_t'(5'(k + 8));
    endfunction

    function automatic ex_pipe_pkg::issue_slot_t rand_slot(input ex_isa_pkg::opcode_t op);
        ex_pipe_pkg::issue_slot_t s;
        logic [31:0] r;
        s = '0;
        s.valid   = 1'b1;
        s.opcode  = op;
        r = $random(seed);
        s.pc      = r & ~32'h3;
        s.src1    = $random(seed);
        s.src2    = $random(seed);
        r = $random(seed);
        s.dest    = r[4:0];
        s.pred_branch_taken = r[8];
        s.st_data = $random(seed);
        return s;
    endfunction

    // ----------------------------------------
    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            $display("CHECK FAILED %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic compare_slot(input string l, input ex_pipe_pkg::ex_slot_t e,
                                input ex_pipe_pkg::ex_slot_t g);
        check_val({l, ".valid"}, 32'(e.valid), 32'(g.valid));
        if (e.valid) begin
            check_val({l, ".forwardable"}, 32'(e.forwardable), 32'(g.forwardable));
            check_val({l, ".pc"}, e.pc, g.pc);
            check_val({l, ".have_exception"}, 32'(e.have_exception), 32'(g.have_exception));
            check_val({l, ".exception_type"}, 32'(e.exception_type), 32'(g.exception_type));
            check_val({l, ".result"}, e.result, g.result);
            check_val({l, ".dest"}, 32'(e.dest), 32'(g.dest));
            check_val({l, ".branch_taken"}, 32'(e.branch_taken), 32'(g.branch_taken));
            check_val({l, ".branch_target"}, e.branch_target, g.branch_target);
            check_val({l, ".branch_mistaken"}, 32'(e.branch_mistaken), 32'(g.branch_mistaken));
            check_val({l, ".mem_type"}, 32'(e.mem_type), 32'(g.mem_type));
            check_val({l, ".mem_size"}, 32'(e.mem_size), 32'(g.mem_size));
            check_val({l, ".st_data"}, e.st_data, g.st_data);
            check_val({l, ".is_csr_op"}, 32'(e.is_csr_op), 32'(g.is_csr_op));
            check_val({l, ".csr_addr"}, 32'(e.csr_addr), 32'(g.csr_addr));
            check_val({l, ".csr_mask"}, e.csr_mask, g.csr_mask);
        end
    endtask

    // back-pressure driver.
    always @(posedge clk) begin : bp_drive
        logic [31:0] r;
        #2;
        r = $random(seed);
        allowout = bp_on ? r[0] : 1'b1;
    end

    // sampled at the falling edge, when outputs are settled.
    always @(negedge clk) begin
        if (arst_n) begin
            if (ex_ready && allowout) begin
                assert (exp_a_q.size() > 0) else begin
                    $display("a bundle left the stage with no bundle expected");
                    errors++;
                end
                if (exp_a_q.size() > 0) begin
                    compare_slot("ex_a", exp_a_q.pop_front(), ex_a);
                    compare_slot("ex_b", exp_b_q.pop_front(), ex_b);
                    done_cnt++;
                end
            end
            if (ex_valid && !ex_ready) begin
                check_val("ex_stall", 32'd1, 32'(ex_stall));
            end
            if (!allowout) begin
                check_val("ex_a.branch_mistaken", 32'd0, 32'(ex_a.branch_mistaken));
                check_val("ex_b.branch_mistaken", 32'd0, 32'(ex_b.branch_mistaken));
            end
        end
    end

    // outputs held under back-pressure, compared without branch_mistaken.
    always @(negedge clk) begin : hold_check
        ex_pipe_pkg::ex_slot_t ha;
        ex_pipe_pkg::ex_slot_t hb;
        logic held;
        if (arst_n && held) begin
            ha.branch_mistaken = ex_a.branch_mistaken;
            hb.branch_mistaken = ex_b.branch_mistaken;
            assert (ha === ex_a && hb === ex_b) else begin
                $display("outputs changed while the memory stage held the bundle");
                errors++;
            end
        end
        held = arst_n & ex_ready & !allowout & !flush;
        ha = ex_a;
        hb = ex_b;
    end

    // ----------------------------------------
    task automatic send(input ex_pipe_pkg::issue_slot_t a, input ex_pipe_pkg::issue_slot_t b);
        int t;
        ro_a = a;
        ro_b = b;
        ro_ready = 1'b1;
        t = 0;
        @(negedge clk);
        while (ex_stall && t < 200) begin
            @(negedge clk);
            t++;
        end
        if (t >= 200) begin
            $display("timeout: the stage never accepted a bundle");
            errors++;
        end else begin
            exp_a_q.push_back(ex_ref(a));
            exp_b_q.push_back(ex_ref(b));
            sent++;
        end
        @(posedge clk);
        #2;
        ro_ready = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (exp_a_q.size() > 0 && t < 500) begin
            @(posedge clk);
            t++;
        end
        if (t >= 500) begin
            $display("timeout: queued bundles never left the stage");
            errors++;
        end
        #2;
    endtask

    task automatic branch_pair();
        ex_pipe_pkg::issue_slot_t s[2];
        ex_pipe_pkg::ex_slot_t    e;
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            r = $random(seed);
            s[i] = rand_slot(r[0] ? pick_op(2, 3) : ex_isa_pkg::OP_ADD);
            s[i].is_branch          = 1'b1;
            s[i].is_jirl            = !r[0];
            s[i].branch_condition   = r[1];
            s[i].branch_target      = $random(seed);
            e = ex_ref(s[i]);
            s[i].pred_branch_target = r[2] ? e.branch_target : 32'($random(seed));
        end
        send(s[0], s[1]);
    endtask

    initial begin
        arst_n   = 1'b0;
        flush    = 1'b0;
        allowout = 1'b1;
        ro_ready = 1'b0;
        bp_on    = 1'b0;
        ro_a     = '0;
        ro_b     = '0;
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        // alu ops leave in the first cycle after capture.
        repeat (20) begin
            send(rand_slot(pick_op(0, 13)), rand_slot(pick_op(0, 13)));
            @(negedge clk);
            check_val("ex_ready", 32'd1, 32'(ex_ready));
            @(posedge clk);
            #2;
        end
        repeat (12) send(rand_slot(pick_op(13, 3)), rand_slot(pick_op(0, 16)));
        for (int i = 0; i < 16; i++) begin
            ro_a = rand_slot(pick_op(16, 4));
            if (i % 4 == 0) ro_a.src2 = '0;
            if (i % 3 == 0) ro_a.src1 = -32'sd7;
            send(ro_a, rand_slot(i[0] ? pick_op(16, 4) : pick_op(0, 13)));
        end
        repeat (16) branch_pair();
        drain();
        bp_on = 1'b1;
        repeat (30) send(rand_slot(pick_op(0, 20)), rand_slot(pick_op(0, 20)));
        drain();
        bp_on = 1'b0;
        // flush a divide in flight.
        send(rand_slot(ex_isa_pkg::OP_DIV), rand_slot(ex_isa_pkg::OP_ADD));
        repeat (4) @(posedge clk);
        #2 flush = 1'b1;
        void'(exp_a_q.pop_back());
        void'(exp_b_q.pop_back());
        sent--;
        @(posedge clk);
        #2 flush = 1'b0;
        check_val("ex_valid", 32'd0, 32'(ex_valid));
        ro_a = rand_slot(ex_isa_pkg::OP_OR);
        ro_a.have_exception = 1'b1;
        ro_a.exception_type = ex_isa_pkg::EXC_INE;
        ro_b = rand_slot(ex_isa_pkg::OP_SUB);
        ro_b.mem_type = ex_isa_pkg::MEM_STORE;
        send(ro_a, ro_b);
        ro_a = rand_slot(ex_isa_pkg::OP_DIVU);
        ro_a.is_csr_op = 1'b1;
        ro_a.csr_addr  = 14'h0c0;
        send(ro_a, rand_slot(ex_isa_pkg::OP_XOR));
        drain();
        // reset with a divide in flight.
        send(rand_slot(ex_isa_pkg::OP_MODU), rand_slot(ex_isa_pkg::OP_MOD));
        arst_n = 1'b0;
        exp_a_q.delete();
        exp_b_q.delete();
        sent--;
        repeat (5) @(posedge clk);
        check_val("ex_valid", 32'd0, 32'(ex_valid));
        #2 arst_n = 1'b1;
        send(rand_slot(ex_isa_pkg::OP_MOD), rand_slot(ex_isa_pkg::OP_MULH));
        drain();
        assert (done_cnt == sent) else begin
            $display("bundle count mismatch, %0d sent and %0d compared", sent, done_cnt);
            errors++;
        end
        $display("errors %0d, checks %0d, bundles %0d", errors, checks, done_cnt);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hdl
hdl/ex_isa_pkg.sv
hdl/ex_pipe_pkg.sv
hdl/ex_alu.sv
hdl/ex_muldiv.sv
hdl/ex_branch.sv
hdl/ex_ctrl.sv
hdl/ex_stage.sv
testbench/ex_stage_tb.sv

// File: Makefile
SIM      := verilator
TOP      := ex_stage_tb
FILELIST := all.f
FLAGS    := --binary --timing --assert --top-module $(TOP)
OBJDIR   := obj_dir
BIN      := $(OBJDIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := Regression passed

SRCS := $(shell grep -v '^+' $(FILELIST)) hdl/ex_cfg.svh

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
